// File: trs_video.f
rtl/trs_video_pkg.sv
rtl/trs_video_timing.sv
rtl/trs_video_bus.sv
rtl/trs_char_render.sv
rtl/trs_video.sv
testbench/trs_video_properties.sv
testbench/trs_video_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the trs_video testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

# a build error or an assertion stop also counts as failure
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module trs_video_tb -f trs_video.f -o trs_video_sim > "$LOG" 2>&1 \
   && ./obj_dir/trs_video_sim >> "$LOG" 2>&1 \
   || echo "CHECKS FAILED" >> "$LOG"

cat "$LOG"
grep -q "CHECKS FAILED" "$LOG" && exit 1 || exit 0

// File: testbench/trs_video_tb.sv
`default_nettype none

module trs_video_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int FRAME_CYCLES = 420000;
   // first partial frame plus five two-frame measurements, with margin
   localparam int CYCLE_LIMIT  = 12 * FRAME_CYCLES;
   localparam trs_video_pkg::byte_t BLANK_CODE = 8'h20;  // glyph kept all zero
   localparam trs_video_pkg::byte_t BLOCK_CODE = 8'hBF;  // all six blocks lit

   logic                     vga_clk;
   logic                     arst_n;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   trs_video_pkg::wb_addr_t  wb_adr;
   trs_video_pkg::byte_t     wb_dat_w;
   logic                     wb_sel;
   trs_video_pkg::byte_t     wb_dat_r;
   logic                     wb_ack;
   logic                     pixel_data;
   logic                     h_sync;
   logic                     v_sync;

   int   cycle_cnt = 0;
   int   pix_cnt   = 0;     // high pixels so far in this frame
   int   frame_pix = 0;     // total of the last whole frame
   int   frame_seq = 0;     // v_sync rises seen
   logic v_sync_q  = 1'b0;

   trs_video u_dut (
      .vga_clk    (vga_clk),
      .arst_n     (arst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_sel     (wb_sel),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .pixel_data (pixel_data),
      .h_sync     (h_sync),
      .v_sync     (v_sync)
   );

   initial
   begin
      vga_clk = 1'b0;
      forever #10 vga_clk = ~vga_clk;  // 50 MHz
   end

   // frame pixel count, sampled mid cycle
   always @(negedge vga_clk)
   begin
      v_sync_q <= v_sync;
      if (v_sync && !v_sync_q)  // frame boundary
      begin
         frame_pix <= pix_cnt;
         pix_cnt   <= 0;
         frame_seq <= frame_seq + 1;
      end
      else if (pixel_data)
         pix_cnt <= pix_cnt + 1;
   end

   always @(posedge vga_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("timeout, the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("CHECKS FAILED");
         $fatal(1, "run stopped by timeout");
      end
   end

   task automatic check_equal(input string what, input int got, input int expected);
      assert (got == expected)
      else
      begin
         $display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
         $display("CHECKS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // one classic cycle, stb held until ack
   task automatic access_bus(input logic we, input trs_video_pkg::wb_addr_t adr,
                             input trs_video_pkg::byte_t wdat,
                             output trs_video_pkg::byte_t rdat);
      int waits;
      waits = 0;
      @(negedge vga_clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      wb_sel   = 1'b1;
      @(negedge vga_clk);
      while (!wb_ack && waits < 4)
      begin
         @(negedge vga_clk);
         waits = waits + 1;
      end
      if (!wb_ack)
      begin
         $display("no bus acknowledge for address %h", adr);
         $display("CHECKS FAILED");
         $fatal(1, "bus hang");
      end
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge vga_clk);  // slave back to idle before next strobe
   endtask

   task automatic write_byte(input trs_video_pkg::wb_addr_t adr, input trs_video_pkg::byte_t dat);
      trs_video_pkg::byte_t unused_rd;
      access_bus(1'b1, adr, dat, unused_rd);
   endtask

   task automatic read_byte(input trs_video_pkg::wb_addr_t adr, output trs_video_pkg::byte_t dat);
      access_bus(1'b0, adr, 8'h00, dat);
   endtask

   task automatic place_code(input logic [3:0] r, input logic [5:0] c,
                             input trs_video_pkg::byte_t code);
      write_byte(trs_video_pkg::WB_DSP_BASE + {2'b00, r, c}, code);
   endtask

   // drop the frame the writes fell in, keep the next whole one
   task automatic count_frame(output int pixels);
      int start;
      start = frame_seq;
      wait (frame_seq == start + 2);
      pixels = frame_pix;
   endtask

   initial
   begin
      trs_video_pkg::byte_t wd;
      trs_video_pkg::byte_t rd;
      trs_video_pkg::byte_t glyph_row;
      logic [9:0]           addr;
      logic [3:0]           cell_row;
      logic [5:0]           cell_col;
      logic [6:0]           text_code;
      int                   pixels;
      int                   expected;
      int                   i;
      void'($urandom(32'h5d426234));
      arst_n   = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = 1'b0;
      repeat (8) @(negedge vga_clk);
      arst_n = 1'b1;

      // read-back of each target, then an unmapped address
      wd   = 8'($urandom);
      addr = 10'($urandom);
      write_byte(trs_video_pkg::WB_DSP_BASE + {2'b00, addr}, wd);
      read_byte(trs_video_pkg::WB_DSP_BASE + {2'b00, addr}, rd);
      check_equal("display RAM read-back", int'(rd), int'(wd));
      wd   = 8'($urandom);
      addr = 10'($urandom);
      write_byte(trs_video_pkg::WB_GLYPH_BASE + {2'b00, addr}, wd);
      read_byte(trs_video_pkg::WB_GLYPH_BASE + {2'b00, addr}, rd);
      check_equal("glyph RAM read-back", int'(rd), int'(wd));
      wd = 8'($urandom);
      write_byte(trs_video_pkg::WB_CTRL_ADDR, wd);
      read_byte(trs_video_pkg::WB_CTRL_ADDR, rd);
      check_equal("control register read-back", int'(rd), int'(wd));
      write_byte(trs_video_pkg::WB_CTRL_ADDR, 8'h00);
      read_byte(12'hC00 + {2'b00, addr}, rd);  // top 1k is unmapped
      check_equal("unmapped read", int'(rd), 255);

      // blank screen and an empty glyph for the blank code
      for (i = 0; i < 1024; i++)
         write_byte(trs_video_pkg::WB_DSP_BASE + 12'(i), BLANK_CODE);
      for (i = 0; i < 8; i++)
         write_byte(trs_video_pkg::WB_GLYPH_BASE + {2'b00, BLANK_CODE[6:0], 3'(i)}, 8'h00);

      // full block, 8 pixels on all 24 lines
      cell_row = 4'($urandom);
      cell_col = 6'($urandom);
      place_code(cell_row, cell_col, BLOCK_CODE);
      count_frame(pixels);
      check_equal("block graphic pixels", pixels, 192);

      // text glyph, each glyph row drawn on two lines
      place_code(cell_row, cell_col, BLANK_CODE);
      text_code = 7'($urandom);
      if (text_code == BLANK_CODE[6:0])
         text_code = 7'h21;
      expected = 0;
      for (i = 0; i < 8; i++)
      begin
         glyph_row = 8'($urandom);
         expected  = expected + 2 * $countones(glyph_row);
         write_byte(trs_video_pkg::WB_GLYPH_BASE + {2'b00, text_code, 3'(i)}, glyph_row);
      end
      cell_row = 4'($urandom);
      cell_col = 6'($urandom);
      place_code(cell_row, cell_col, {1'b0, text_code});
      count_frame(pixels);
      check_equal("text glyph pixels", pixels, expected);

      // inverse video, blank glyph with bit 7 lights the whole cell
      place_code(cell_row, cell_col, BLANK_CODE);
      write_byte(trs_video_pkg::WB_CTRL_ADDR, 8'h01);
      cell_row = 4'($urandom);
      cell_col = 6'($urandom);
      place_code(cell_row, cell_col, {1'b1, BLANK_CODE[6:0]});
      count_frame(pixels);
      check_equal("inverse video pixels", pixels, 192);

      // 32 column mode, even cell doubled and odd cell hidden
      place_code(cell_row, cell_col, BLANK_CODE);
      write_byte(trs_video_pkg::WB_CTRL_ADDR, 8'h02);
      cell_row = 4'($urandom);
      cell_col = {5'($urandom), 1'b0};
      place_code(cell_row, cell_col, BLOCK_CODE);
      count_frame(pixels);
      check_equal("double wide block pixels", pixels, 384);
      place_code(cell_row, cell_col, BLANK_CODE);
      cell_col[0] = 1'b1;
      place_code(cell_row, cell_col, BLOCK_CODE);
      count_frame(pixels);
      check_equal("odd column block pixels", pixels, 0);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/trs_video_properties.sv
`default_nettype none

module trs_video_properties (
   input wire logic vga_clk,
   input wire logic arst_n,
   input wire logic wb_cyc,
   input wire logic wb_stb,
   input wire logic wb_ack,
   input wire logic h_sync,
   input wire logic v_sync
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int LINE_CYCLES  = 800;     // 100 cols x 8 pixels
   localparam int HSYNC_CYCLES = 96;
   localparam int FRAME_CYCLES = 420000;  // 525 lines
   localparam int VSYNC_CYCLES = 1600;    // two lines

   logic h_q;      // syncs one sample back
   logic v_q;
   logic h_seen;   // a first rise was seen, period valid from now on
   logic v_seen;
   int   h_per;    // cycles since last rise
   int   h_len;    // samples of the current high phase
   int   v_per;
   int   v_len;

   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         h_q    <= 1'b0;
         v_q    <= 1'b0;
         h_seen <= 1'b0;
         v_seen <= 1'b0;
         h_per  <= 0;
         h_len  <= 0;
         v_per  <= 0;
         v_len  <= 0;
      end
      else
      begin
         h_q   <= h_sync;
         v_q   <= v_sync;
         h_per <= (h_sync && !h_q) ? 1 : h_per + 1;
         v_per <= (v_sync && !v_q) ? 1 : v_per + 1;
         h_len <= h_sync ? h_len + 1 : 0;
         v_len <= v_sync ? v_len + 1 : 0;
         if (h_sync && !h_q)
            h_seen <= 1'b1;
         if (v_sync && !v_q)
            v_seen <= 1'b1;
      end
   end

   // sync periods and pulse widths
   assert property (@(posedge vga_clk) disable iff (!arst_n)
      (h_sync && !h_q && h_seen) |-> (h_per == LINE_CYCLES))
      else $error("h_sync does not recur every %0d cycles", LINE_CYCLES);
   assert property (@(posedge vga_clk) disable iff (!arst_n)
      (!h_sync && h_q) |-> (h_len == HSYNC_CYCLES))
      else $error("h_sync pulse is not %0d cycles wide", HSYNC_CYCLES);
   assert property (@(posedge vga_clk) disable iff (!arst_n)
      (v_sync && !v_q && v_seen) |-> (v_per == FRAME_CYCLES))
      else $error("v_sync does not recur every %0d cycles", FRAME_CYCLES);
   assert property (@(posedge vga_clk) disable iff (!arst_n)
      (!v_sync && v_q) |-> (v_len == VSYNC_CYCLES))
      else $error("v_sync pulse is not %0d cycles wide", VSYNC_CYCLES);

   // wishbone handshake, ack one cycle after stb and one cycle long
   assert property (@(posedge vga_clk) disable iff (!arst_n)
      (wb_cyc && $rose(wb_stb)) |=> wb_ack)
      else $error("no ack one cycle after stb");
   assert property (@(posedge vga_clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else $error("ack held longer than one cycle");
   assert property (@(posedge vga_clk) disable iff (!arst_n)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else $error("ack without a preceding strobe");

endmodule

bind trs_video trs_video_properties u_props (
   .vga_clk (vga_clk),
   .arst_n  (arst_n),
   .wb_cyc  (wb_cyc),
   .wb_stb  (wb_stb),
   .wb_ack  (wb_ack),
   .h_sync  (h_sync),
   .v_sync  (v_sync)
);

`default_nettype wire

// File: rtl/trs_video.sv
`default_nettype none

module trs_video (
   input  wire logic                     vga_clk,
   input  wire logic                     arst_n,
   input  wire logic                     wb_cyc,
   input  wire logic                     wb_stb,
   input  wire logic                     wb_we,
   input  wire trs_video_pkg::wb_addr_t  wb_adr,
   input  wire trs_video_pkg::byte_t     wb_dat_w,
   input  wire logic                     wb_sel,
   output wire trs_video_pkg::byte_t     wb_dat_r,
   output wire logic                     wb_ack,
   output wire logic                     pixel_data,
   output wire logic                     h_sync,
   output wire logic                     v_sync
);

   wire trs_video_pkg::col_t         col;
   wire trs_video_pkg::sub_x_t       sub_x;
   wire trs_video_pkg::row_t         row;
   wire trs_video_pkg::sub_y_t       sub_y;
   wire logic                        dsp_act;
   wire trs_video_pkg::dsp_addr_t    dsp_raddr;
   wire trs_video_pkg::byte_t        dsp_rdata;
   wire trs_video_pkg::glyph_addr_t  glyph_raddr;
   wire trs_video_pkg::byte_t        glyph_rdata;
   wire logic                        invvide;
   wire logic                        modsel;

   // raster counters and syncs
   trs_video_timing u_timing (
      .vga_clk (vga_clk),
      .arst_n  (arst_n),
      .col     (col),
      .sub_x   (sub_x),
      .row     (row),
      .sub_y   (sub_y),
      .dsp_act (dsp_act),
      .h_sync  (h_sync),
      .v_sync  (v_sync)
   );

   // host port, RAMs, control register
   trs_video_bus u_bus (
      .vga_clk     (vga_clk),
      .arst_n      (arst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_sel      (wb_sel),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .dsp_raddr   (dsp_raddr),
      .dsp_rdata   (dsp_rdata),
      .glyph_raddr (glyph_raddr),
      .glyph_rdata (glyph_rdata),
      .invvide     (invvide),
      .modsel      (modsel)
   );

   // character pipeline
   trs_char_render u_render (
      .vga_clk     (vga_clk),
      .arst_n      (arst_n),
      .col         (col),
      .sub_x       (sub_x),
      .row         (row),
      .sub_y       (sub_y),
      .dsp_act     (dsp_act),
      .dsp_rdata   (dsp_rdata),
      .glyph_rdata (glyph_rdata),
      .invvide     (invvide),
      .modsel      (modsel),
      .dsp_raddr   (dsp_raddr),
      .glyph_raddr (glyph_raddr),
      .pixel_data  (pixel_data)
   );

endmodule

`default_nettype wire

// File: rtl/trs_char_render.sv
`default_nettype none

module trs_char_render (
   input  wire logic                    vga_clk,
   input  wire logic                    arst_n,
   input  wire trs_video_pkg::col_t     col,
   input  wire trs_video_pkg::sub_x_t   sub_x,
   input  wire trs_video_pkg::row_t     row,
   input  wire trs_video_pkg::sub_y_t   sub_y,
   input  wire logic                    dsp_act,
   input  wire trs_video_pkg::byte_t    dsp_rdata,
   input  wire trs_video_pkg::byte_t    glyph_rdata,
   input  wire logic                    invvide,
   input  wire logic                    modsel,
   output trs_video_pkg::dsp_addr_t     dsp_raddr,
   output trs_video_pkg::glyph_addr_t   glyph_raddr,
   output logic                         pixel_data
);

   localparam trs_video_pkg::sub_x_t LATCH_SX = 3'd2;  // code back from display RAM
   localparam trs_video_pkg::sub_x_t LOAD_SX  = 3'd4;  // glyph row back, load shifter

   trs_video_pkg::col_t        txt_col;     // text column, window relative
   trs_video_pkg::row_t        txt_row;
   trs_video_pkg::char_code_t  fetch_code;  // glyph index of the fetched code
   trs_video_pkg::byte_t       code_q;
   trs_video_pkg::sub_y_t      line_q;
   trs_video_pkg::byte_t       glyph_row;
   trs_video_pkg::byte_t       pattern;
   trs_video_pkg::byte_t       shift_q;
   logic                       col_act;
   logic                       act_q;
   logic                       is_block;

   assign txt_col = col - trs_video_pkg::col_t'(trs_video_pkg::DSP_COL_OFS);
   assign txt_row = row - trs_video_pkg::row_t'(trs_video_pkg::DSP_ROW_OFS);
   assign col_act = modsel ? ~txt_col[0] : 1'b1;  // double wide, even cols only

   // display read runs all slot long, data valid from sub_x 1
   assign dsp_raddr = {txt_row[3:0], txt_col[5:0]};

   // glyph read straight off the code, each glyph row drawn twice
   assign fetch_code  = dsp_rdata[6:0];
   assign glyph_raddr = {fetch_code, sub_y[3:1]};

   // latch code and scan line for pattern forming
   always_ff @(posedge vga_clk)
   begin
      if (sub_x == LATCH_SX)
      begin
         code_q <= dsp_rdata;
         line_q <= sub_y;
      end
   end

   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
         act_q <= 1'b0;
      else if (sub_x == LATCH_SX)
         act_q <= dsp_act && col_act;
   end

   // 0x80-0xbf are 2x3 blocks unless inverse video is on
   assign is_block  = (code_q[7:6] == 2'b10) && !invvide;
   assign glyph_row = line_q[4] ? 8'h00 : glyph_rdata;  // glyph lines 8-11 blank

   always_comb
   begin
      if (is_block)
      begin
         case (line_q[4:3])  // band of 4 glyph lines
            2'b00:   pattern = {{4{code_q[0]}}, {4{code_q[1]}}};
            2'b01:   pattern = {{4{code_q[2]}}, {4{code_q[3]}}};
            2'b10:   pattern = {{4{code_q[4]}}, {4{code_q[5]}}};
            default: pattern = 8'h00;  // no such band
         endcase
      end
      else
         pattern = glyph_row ^ {8{code_q[7] & invvide}};  // bit 7 inverts
   end

   // pixel shifter, msb first
   // in 32 column mode load falls on an even sub_x, so it lines up with the shift
   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
         shift_q <= '0;
      else if ((sub_x == LOAD_SX) && act_q)
         shift_q <= pattern;
      else if (!modsel || !sub_x[0])
         shift_q <= {shift_q[6:0], 1'b0};  // zeros fill the border
   end

   assign pixel_data = shift_q[7];

endmodule

`default_nettype wire

// File: rtl/trs_video_bus.sv
`default_nettype none

module trs_video_bus (
   input  wire logic                        vga_clk,
   input  wire logic                        arst_n,
   // wishbone classic slave
   input  wire logic                        wb_cyc,
   input  wire logic                        wb_stb,
   input  wire logic                        wb_we,
   input  wire trs_video_pkg::wb_addr_t     wb_adr,
   input  wire trs_video_pkg::byte_t        wb_dat_w,
   input  wire logic                        wb_sel,
   output trs_video_pkg::byte_t             wb_dat_r,
   output logic                             wb_ack,
   // video read ports
   input  wire trs_video_pkg::dsp_addr_t    dsp_raddr,
   output trs_video_pkg::byte_t             dsp_rdata,
   input  wire trs_video_pkg::glyph_addr_t  glyph_raddr,
   output trs_video_pkg::byte_t             glyph_rdata,
   // control bits
   output logic                             invvide,
   output logic                             modsel
);

   trs_video_pkg::byte_t       dsp_mem   [0:1023];  // 64x16 codes
   trs_video_pkg::byte_t       glyph_mem [0:1023];  // 128 glyphs x 8 rows
   trs_video_pkg::bus_state_t  state;
   trs_video_pkg::byte_t       ctrl_q;
   trs_video_pkg::byte_t       dsp_bus_q;           // bus port read data
   trs_video_pkg::byte_t       glyph_bus_q;
   logic                       bus_go;
   logic                       wr_go;
   logic                       dsp_hit;
   logic                       glyph_hit;
   logic                       ctrl_hit;
   logic                       dsp_hit_q;           // which source feeds wb_dat_r
   logic                       glyph_hit_q;
   logic                       ctrl_hit_q;

   // address decode
   assign dsp_hit   = wb_adr[11:10] == trs_video_pkg::WB_DSP_BASE[11:10];
   assign glyph_hit = wb_adr[11:10] == trs_video_pkg::WB_GLYPH_BASE[11:10];
   assign ctrl_hit  = wb_adr == trs_video_pkg::WB_CTRL_ADDR;

   assign bus_go = wb_cyc && wb_stb && (state == trs_video_pkg::BUS_IDLE);  // new transfer
   assign wr_go  = bus_go && wb_we && wb_sel;

   // idle -> ack -> done, ack exactly one cycle after stb
   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= trs_video_pkg::BUS_IDLE;
      else
      begin
         case (state)
            trs_video_pkg::BUS_IDLE:
               if (bus_go)
                  state <= trs_video_pkg::BUS_ACK;
            trs_video_pkg::BUS_ACK:
               state <= trs_video_pkg::BUS_DONE;
            default:
               if (!(wb_cyc && wb_stb))  // wait for host to drop stb
                  state <= trs_video_pkg::BUS_IDLE;
         endcase
      end
   end

   assign wb_ack = state == trs_video_pkg::BUS_ACK;

   // video control register
   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
         ctrl_q <= '0;
      else if (wr_go && ctrl_hit)
         ctrl_q <= wb_dat_w;
   end

   assign invvide = ctrl_q[trs_video_pkg::CTRL_INVVIDE_BIT];
   assign modsel  = ctrl_q[trs_video_pkg::CTRL_MODSEL_BIT];

   // display RAM, bus port
   always_ff @(posedge vga_clk)
   begin
      if (wr_go && dsp_hit)
         dsp_mem[wb_adr[9:0]] <= wb_dat_w;
      if (bus_go)
         dsp_bus_q <= dsp_mem[wb_adr[9:0]];  // read before write
   end

   // display RAM, video port
   always_ff @(posedge vga_clk)
   begin
      dsp_rdata <= dsp_mem[dsp_raddr];
   end

   // glyph RAM, bus port
   always_ff @(posedge vga_clk)
   begin
      if (wr_go && glyph_hit)
         glyph_mem[wb_adr[9:0]] <= wb_dat_w;
      if (bus_go)
         glyph_bus_q <= glyph_mem[wb_adr[9:0]];
   end

   // glyph RAM, video port
   always_ff @(posedge vga_clk)
   begin
      glyph_rdata <= glyph_mem[glyph_raddr];
   end

   // remember the decode for the ack cycle
   always_ff @(posedge vga_clk)
   begin
      if (bus_go)
      begin
         dsp_hit_q   <= dsp_hit;
         glyph_hit_q <= glyph_hit;
         ctrl_hit_q  <= ctrl_hit;
      end
   end

   // unmapped reads float high
   assign wb_dat_r = dsp_hit_q   ? dsp_bus_q   :
                     glyph_hit_q ? glyph_bus_q :
                     ctrl_hit_q  ? ctrl_q      : 8'hFF;

endmodule

`default_nettype wire

// File: rtl/trs_video_timing.sv
`default_nettype none

module trs_video_timing (
   input  wire logic                 vga_clk,
   input  wire logic                 arst_n,
   output trs_video_pkg::col_t       col,
   output trs_video_pkg::sub_x_t     sub_x,
   output trs_video_pkg::row_t       row,
   output trs_video_pkg::sub_y_t     sub_y,
   output logic                      dsp_act,
   output logic                      h_sync,
   output logic                      v_sync
);

   trs_video_pkg::col_t dsp_col;  // column inside text window
   trs_video_pkg::row_t dsp_row;
   logic                line_end;
   logic                frame_end;

   assign line_end  = (sub_x == 3'd7) &&
                      (col == trs_video_pkg::col_t'(trs_video_pkg::COLS_TOTAL - 1));
   // last row is short, 21 lines
   assign frame_end = (row == trs_video_pkg::row_t'(trs_video_pkg::ROWS_TOTAL - 1)) &&
                      (sub_y == trs_video_pkg::sub_y_t'(trs_video_pkg::LAST_ROW_LINES - 1));

   // nested counters, pixel -> column -> scan line -> row
   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sub_x <= '0;
         col   <= '0;
         sub_y <= '0;
         row   <= '0;
      end
      else
      begin
         sub_x <= sub_x + 3'd1;  // wraps at 8
         if (sub_x == 3'd7)
         begin
            if (line_end)
            begin
               col <= '0;
               if (frame_end)
               begin
                  sub_y <= '0;
                  row   <= '0;
               end
               else if (sub_y == trs_video_pkg::sub_y_t'(trs_video_pkg::LINES_PER_ROW - 1))
               begin
                  sub_y <= '0;
                  row   <= row + 5'd1;
               end
               else
                  sub_y <= sub_y + 5'd1;
            end
            else
               col <= col + 7'd1;
         end
      end
   end

   // offsets wrap negative to large values, so one compare each
   assign dsp_col = col - trs_video_pkg::col_t'(trs_video_pkg::DSP_COL_OFS);
   assign dsp_row = row - trs_video_pkg::row_t'(trs_video_pkg::DSP_ROW_OFS);
   assign dsp_act = (dsp_col < trs_video_pkg::col_t'(trs_video_pkg::DSP_COLS)) &&
                    (dsp_row < trs_video_pkg::row_t'(trs_video_pkg::DSP_ROWS));

   // registered syncs, 96 clocks of h_sync and two lines of v_sync
   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         h_sync <= 1'b0;
         v_sync <= 1'b0;
      end
      else
      begin
         if ({col, sub_x} == trs_video_pkg::HSYNC_ON)
            h_sync <= 1'b1;
         else if ({col, sub_x} == trs_video_pkg::HSYNC_OFF)
            h_sync <= 1'b0;

         if ({row, sub_y} == trs_video_pkg::VSYNC_ON_LINE)
            v_sync <= 1'b1;
         else if ({row, sub_y} == trs_video_pkg::VSYNC_OFF_LINE)
            v_sync <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: rtl/trs_video_pkg.sv
`default_nettype none

package trs_video_pkg;

   // vector types
   typedef logic [7:0]  byte_t;        // bus data, display codes, glyph rows
   typedef logic [6:0]  char_code_t;   // glyph RAM index
   typedef logic [6:0]  col_t;         // 0-99
   typedef logic [2:0]  sub_x_t;       // pixel within char
   typedef logic [4:0]  row_t;         // 0-21
   typedef logic [4:0]  sub_y_t;       // scan line within row, 0-23
   typedef logic [9:0]  dsp_addr_t;    // row*64 + col
   typedef logic [9:0]  glyph_addr_t;  // code*8 + glyph row
   typedef logic [11:0] wb_addr_t;

   // bus slave FSM
   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_ACK,
      BUS_DONE
   } bus_state_t;

   // 640x480 raster in 8x24 cells
   localparam int COLS_TOTAL     = 100;  // 80 active
   localparam int LINES_PER_ROW  = 24;
   localparam int ROWS_TOTAL     = 22;
   localparam int LAST_ROW_LINES = 21;   // 21*24 + 21 = 525 lines

   // centring of the 64x16 text window
   localparam int DSP_COL_OFS = 8;
   localparam int DSP_ROW_OFS = 2;
   localparam int DSP_COLS    = 64;
   localparam int DSP_ROWS    = 16;

   // sync compare points, {col, sub_x} and {row, sub_y}
   localparam logic [9:0] HSYNC_ON       = {7'd82, 3'd2};
   localparam logic [9:0] HSYNC_OFF      = {7'd94, 3'd2};
   localparam logic [9:0] VSYNC_ON_LINE  = {5'd20, 5'd9};
   localparam logic [9:0] VSYNC_OFF_LINE = {5'd20, 5'd11};

   // bus address map
   localparam wb_addr_t WB_DSP_BASE   = 12'h000;  // 1k display RAM
   localparam wb_addr_t WB_CTRL_ADDR  = 12'h400;  // video control
   localparam wb_addr_t WB_GLYPH_BASE = 12'h800;  // 1k glyph RAM

   // control register bits
   localparam int CTRL_INVVIDE_BIT = 0;  // inverse video
   localparam int CTRL_MODSEL_BIT  = 1;  // 32 column mode

endpackage

`default_nettype wire
